// ==== rtl/kd_tree_defines.svh ====
// KD-tree search accelerator constants for tree shape, patch format and bus mapping
`ifndef KD_TREE_DEFINES_SVH
`define KD_TREE_DEFINES_SVH

// Tree shape
// Levels of internal nodes, one pipeline stage per level
`define KD_DEPTH 6

// Internal nodes in heap order, 2^KD_DEPTH - 1
`define KD_NODES 63

// Patch format
// Components per patch
`define KD_DIMS 5

// Bits per component, also the width of each node field
`define KD_COMP_W 11

// Bus mapping
// Byte address of node 0, node n sits at base + 4n
`define KD_WB_BASE 32'h3000_0000

`endif

// ==== rtl/kd_tree_pkg.sv ====
// KD-tree package with node word, patch, node address and leaf index types
`include "kd_tree_defines.svh"

package kd_tree_pkg;

  // One unsigned patch component
  typedef logic [`KD_COMP_W-1:0] comp_t;

  // Five components, component 0 in the low bits
  typedef comp_t [`KD_DIMS-1:0] patch_t;

  // Stored node word
  // Median sits in bus bits 21:11, split dimension in bits 10:0
  typedef struct packed {
    comp_t median;     // Threshold, go right when component >= median
    comp_t split_dim;  // Legal values 0 to KD_DIMS-1
  } node_word_t;

  // Heap-ordered node number, 0 to KD_NODES-1
  typedef logic [`KD_DEPTH-1:0] node_addr_t;

  // Leaf number, one decision bit per level, root decision in the MSB
  typedef logic [`KD_DEPTH-1:0] leaf_idx_t;

endpackage

// ==== rtl/internal_node.sv ====
// KD-tree internal node holding one split word and steering both lanes to a child
`include "kd_tree_defines.svh"

module internal_node import kd_tree_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wen_i,              // One-hot slice from the loader
  input  node_word_t wdata_i,
  input  logic       valid_i,            // Lane A patch is at this node
  input  logic       valid_two_i,        // Lane B patch is at this node
  input  patch_t     patch_i,
  input  patch_t     patch_two_i,
  output logic       valid_left_o,
  output logic       valid_right_o,
  output logic       valid_left_two_o,
  output logic       valid_right_two_o,
  output node_word_t rdata_o             // Readback for the bus
);

  localparam int DIM_W = $clog2(`KD_DIMS);

  node_word_t word_q;
  logic [DIM_W-1:0] dim_sel;
  comp_t comp_a, comp_b;
  logic right_a, right_b;

  // Node word, all zero after reset means dimension 0 and median 0
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      word_q <= '0;
    end else if (wen_i) begin
      word_q <= wdata_i;  // Usable from the next cycle
    end
  end

  // Illegal split dimensions fall back to component 0
  assign dim_sel = (word_q.split_dim < `KD_DIMS) ? word_q.split_dim[DIM_W-1:0] : '0;

  assign comp_a = patch_i[dim_sel];
  assign comp_b = patch_two_i[dim_sel];

  // Both lanes share the split word but compare independently
  assign right_a = (comp_a >= word_q.median);
  assign right_b = (comp_b >= word_q.median);

  assign valid_right_o     = valid_i & right_a;
  assign valid_left_o      = valid_i & ~right_a;
  assign valid_right_two_o = valid_two_i & right_b;
  assign valid_left_two_o  = valid_two_i & ~right_b;

  assign rdata_o = word_q;

  // A patch never goes to both children
  a_one_child_a: assert property (@(posedge clk) disable iff (!rst_n)
    !(valid_left_o && valid_right_o))
    else $error("lane A valid sent to both children");

  a_one_child_b: assert property (@(posedge clk) disable iff (!rst_n)
    !(valid_left_two_o && valid_right_two_o))
    else $error("lane B valid sent to both children");

endmodule

// ==== rtl/node_loader.sv ====
// KD-tree node loader with Wishbone slave and streaming write port for node words
`include "kd_tree_defines.svh"

module node_loader import kd_tree_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wb_mode_i,       // 1 = bus owns the nodes, 0 = streaming
  input  logic                fsm_en_i,
  input  logic                sender_en_i,
  input  node_word_t          sender_data_i,
  input  logic                wbs_cyc_i,
  input  logic                wbs_stb_i,
  input  logic                wbs_we_i,
  input  logic [3:0]          wbs_sel_i,
  input  logic [31:0]         wbs_adr_i,
  input  logic [31:0]         wbs_dat_i,
  output logic                wbs_ack_o,
  output logic [31:0]         wbs_dat_o,
  output logic [`KD_NODES-1:0] node_wen_o,     // One-hot write enable per node
  output node_word_t          node_wdata_o,
  input  node_word_t          node_rdata_i [`KD_NODES]
);

  localparam int NODE_W = $bits(node_word_t);

  node_addr_t stream_addr_q;   // Auto-incrementing streaming address
  logic ack_q;
  logic [31:0] dat_q;

  logic [31:0] wb_off;
  logic wb_hit, wb_req, wb_wr, stream_wr, wr_en;
  node_addr_t wb_node, wr_addr;
  node_word_t cur_word, rd_word;
  logic [NODE_W-1:0] wb_bits;

  // Bus address decode
  assign wb_off = wbs_adr_i - `KD_WB_BASE;  // Below base wraps high and misses
  assign wb_hit = (wb_off[1:0] == 2'b00) && (wb_off[31:2] < `KD_NODES);
  assign wb_node = wb_hit ? node_addr_t'(wb_off[7:2]) : '0;  // Clamp keeps index legal

  // New request only when the last one was acked, nothing served in streaming mode
  assign wb_req = wb_mode_i & wbs_cyc_i & wbs_stb_i & ~ack_q;
  assign wb_wr  = wb_req & wbs_we_i & wb_hit;  // Misses are acked but write nothing

  assign stream_wr = ~wb_mode_i & fsm_en_i & sender_en_i;

  // Current contents of the addressed node
  assign cur_word = node_rdata_i[wb_node];
  assign rd_word  = wb_hit ? cur_word : '0;

  // Byte lanes merge into the stored word, sel 4'hF replaces it whole
  always_comb begin
    for (int i = 0; i < NODE_W; i++) begin
      wb_bits[i] = wbs_sel_i[i / 8] ? wbs_dat_i[i] : cur_word[i];
    end
  end

  // Write port shared by both sources
  assign wr_en   = wb_wr | stream_wr;
  assign wr_addr = wb_mode_i ? wb_node : stream_addr_q;

  assign node_wen_o   = {{(`KD_NODES-1){1'b0}}, wr_en} << wr_addr;
  assign node_wdata_o = wb_mode_i ? node_word_t'(wb_bits) : sender_data_i;

  // Streaming counter, parked at 0 while the bus owns the nodes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stream_addr_q <= '0;
    end else if (wb_mode_i) begin
      stream_addr_q <= '0;
    end else if (stream_wr) begin
      if (stream_addr_q == node_addr_t'(`KD_NODES - 1)) begin
        stream_addr_q <= '0;  // Wrap after the last node
      end else begin
        stream_addr_q <= stream_addr_q + 1'b1;
      end
    end
  end

  // Single-cycle ack one clock after acceptance
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_req;
    end
  end

  // Read data captured on acceptance, zero-extended
  always_ff @(posedge clk) begin
    if (wb_req) begin
      dat_q <= wbs_we_i ? '0 : {{(32-NODE_W){1'b0}}, rd_word};
    end
  end

  assign wbs_ack_o = ack_q;
  assign wbs_dat_o = dat_q;

  a_wen_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(node_wen_o))
    else $error("more than one node write enable active");

  // Master drops stb on ack, so a second ack would be a phantom cycle
  a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    wbs_ack_o |=> !wbs_ack_o)
    else $error("wishbone ack held for two cycles");

endmodule

// ==== rtl/internal_node_tree.sv ====
// KD-tree of 63 internal nodes, pipelined one level per clock for two query lanes
`include "kd_tree_defines.svh"

module internal_node_tree import kd_tree_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`KD_NODES-1:0] node_wen_i,
  input  node_word_t           node_wdata_i,
  output node_word_t           node_rdata_o [`KD_NODES],
  input  logic                 patch_en_i,       // Lane A patch valid
  input  logic                 patch_two_en_i,   // Lane B patch valid
  input  patch_t               patch_a_i,
  input  patch_t               patch_b_i,
  output leaf_idx_t            leaf_index_o,
  output leaf_idx_t            leaf_index_two_o,
  output logic                 receiver_en_o,
  output logic                 receiver_two_en_o
);

  localparam int LEAVES = 1 << `KD_DEPTH;

  // Patches held for levels 1 to KD_DEPTH-1, level 0 reads the ports
  patch_t patch_a_q [1:`KD_DEPTH-1];
  patch_t patch_b_q [1:`KD_DEPTH-1];

  // Registered valid per node below the root, heap indexed
  logic [`KD_NODES-1:1] valid_a_q, valid_b_q;
  logic [`KD_NODES-1:0] node_vin_a, node_vin_b;

  // Child valids in heap order, node n feeds 2n+1 and 2n+2
  wire [2*`KD_NODES:1] child_a, child_b;

  // Leaf level valids, leaf k is heap index KD_NODES + k
  logic [LEAVES-1:0] leaf_a_q, leaf_b_q;

  logic [`KD_DEPTH-1:0] track_a, track_b;

  // Root takes the patch enables directly
  assign node_vin_a = {valid_a_q, patch_en_i};
  assign node_vin_b = {valid_b_q, patch_two_en_i};

  for (genvar lvl = 0; lvl < `KD_DEPTH; lvl++) begin : g_level
    patch_t lvl_pa, lvl_pb;

    if (lvl == 0) begin : g_in
      assign lvl_pa = patch_a_i;
      assign lvl_pb = patch_b_i;
    end else begin : g_reg
      assign lvl_pa = patch_a_q[lvl];
      assign lvl_pb = patch_b_q[lvl];
    end

    for (genvar pos = 0; pos < (1 << lvl); pos++) begin : g_node
      localparam int N = (1 << lvl) + pos - 1;  // Heap number

      internal_node u_node (
        .clk               (clk),
        .rst_n             (rst_n),
        .wen_i             (node_wen_i[N]),
        .wdata_i           (node_wdata_i),
        .valid_i           (node_vin_a[N]),
        .valid_two_i       (node_vin_b[N]),
        .patch_i           (lvl_pa),
        .patch_two_i       (lvl_pb),
        .valid_left_o      (child_a[2*N+1]),
        .valid_right_o     (child_a[2*N+2]),
        .valid_left_two_o  (child_b[2*N+1]),
        .valid_right_two_o (child_b[2*N+2]),
        .rdata_o           (node_rdata_o[N])
      );
    end
  end

  // Patch pipeline, payload only
  always_ff @(posedge clk) begin
    patch_a_q[1] <= patch_a_i;
    patch_b_q[1] <= patch_b_i;
    for (int l = 2; l < `KD_DEPTH; l++) begin
      patch_a_q[l] <= patch_a_q[l-1];
      patch_b_q[l] <= patch_b_q[l-1];
    end
  end

  // Valid pipeline, one level per clock
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_a_q <= '0;
      valid_b_q <= '0;
      leaf_a_q  <= '0;
      leaf_b_q  <= '0;
    end else begin
      {leaf_a_q, valid_a_q} <= child_a;  // Split at heap index KD_NODES
      {leaf_b_q, valid_b_q} <= child_b;
    end
  end

  // Latency trackers, KD_DEPTH stages to match the valid pipeline
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      track_a <= '0;
      track_b <= '0;
    end else begin
      track_a <= {track_a[`KD_DEPTH-2:0], patch_en_i};
      track_b <= {track_b[`KD_DEPTH-2:0], patch_two_en_i};
    end
  end

  assign receiver_en_o     = track_a[`KD_DEPTH-1];
  assign receiver_two_en_o = track_b[`KD_DEPTH-1];

  // One-hot leaf vector to leaf number, zero when nothing arrived
  function automatic leaf_idx_t leaf_encode(input logic [LEAVES-1:0] hot);
    leaf_idx_t idx;
    idx = '0;
    for (int k = 0; k < LEAVES; k++) begin
      if (hot[k]) begin
        idx = leaf_idx_t'(k);
      end
    end
    return idx;
  endfunction

  assign leaf_index_o     = leaf_encode(leaf_a_q);
  assign leaf_index_two_o = leaf_encode(leaf_b_q);

  // Tracker and node valids must agree after six levels of steering
  a_leaf_a: assert property (@(posedge clk) disable iff (!rst_n)
    receiver_en_o ? $onehot(leaf_a_q) : (leaf_a_q == '0))
    else $error("lane A leaf vector disagrees with receiver enable");

  a_leaf_b: assert property (@(posedge clk) disable iff (!rst_n)
    receiver_two_en_o ? $onehot(leaf_b_q) : (leaf_b_q == '0))
    else $error("lane B leaf vector disagrees with receiver enable");

endmodule

// ==== rtl/kd_search_top.sv ====
// KD-tree search accelerator top joining the node loader and the pipelined tree
`include "kd_tree_defines.svh"

module kd_search_top import kd_tree_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // Load control and streaming port
  input  logic        wb_mode_i,
  input  logic        fsm_en_i,
  input  logic        sender_en_i,
  input  node_word_t  sender_data_i,
  // Query lanes
  input  logic        patch_en_i,
  input  logic        patch_two_en_i,
  input  patch_t      patch_a_i,
  input  patch_t      patch_b_i,
  output leaf_idx_t   leaf_index_o,
  output leaf_idx_t   leaf_index_two_o,
  output logic        receiver_en_o,
  output logic        receiver_two_en_o,
  // Wishbone slave
  input  logic        wbs_cyc_i,
  input  logic        wbs_stb_i,
  input  logic        wbs_we_i,
  input  logic [3:0]  wbs_sel_i,
  input  logic [31:0] wbs_adr_i,
  input  logic [31:0] wbs_dat_i,
  output logic        wbs_ack_o,
  output logic [31:0] wbs_dat_o
);

  logic [`KD_NODES-1:0] node_wen;
  node_word_t node_wdata;
  node_word_t node_rdata [`KD_NODES];  // All node words for bus readback

  node_loader u_loader (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_mode_i     (wb_mode_i),
    .fsm_en_i      (fsm_en_i),
    .sender_en_i   (sender_en_i),
    .sender_data_i (sender_data_i),
    .wbs_cyc_i     (wbs_cyc_i),
    .wbs_stb_i     (wbs_stb_i),
    .wbs_we_i      (wbs_we_i),
    .wbs_sel_i     (wbs_sel_i),
    .wbs_adr_i     (wbs_adr_i),
    .wbs_dat_i     (wbs_dat_i),
    .wbs_ack_o     (wbs_ack_o),
    .wbs_dat_o     (wbs_dat_o),
    .node_wen_o    (node_wen),
    .node_wdata_o  (node_wdata),
    .node_rdata_i  (node_rdata)
  );

  internal_node_tree u_tree (
    .clk               (clk),
    .rst_n             (rst_n),
    .node_wen_i        (node_wen),
    .node_wdata_i      (node_wdata),
    .node_rdata_o      (node_rdata),
    .patch_en_i        (patch_en_i),
    .patch_two_en_i    (patch_two_en_i),
    .patch_a_i         (patch_a_i),
    .patch_b_i         (patch_b_i),
    .leaf_index_o      (leaf_index_o),
    .leaf_index_two_o  (leaf_index_two_o),
    .receiver_en_o     (receiver_en_o),
    .receiver_two_en_o (receiver_two_en_o)
  );

endmodule

// ==== tb/kd_search_checker.sv ====
// KD-tree search checker with shadow node copy, reference walk and per-lane result queues
`include "kd_tree_defines.svh"

module kd_search_checker import kd_tree_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wb_mode_i,
  input  logic        fsm_en_i,
  input  logic        sender_en_i,
  input  node_word_t  sender_data_i,
  input  logic        patch_en_i,
  input  logic        patch_two_en_i,
  input  patch_t      patch_a_i,
  input  patch_t      patch_b_i,
  input  logic        receiver_en_i,
  input  logic        receiver_two_en_i,
  input  leaf_idx_t   leaf_index_i,
  input  leaf_idx_t   leaf_index_two_i,
  input  logic        wbs_cyc_i,
  input  logic        wbs_stb_i,
  input  logic        wbs_we_i,
  input  logic [31:0] wbs_adr_i,
  input  logic [31:0] wbs_dat_i,
  input  logic        wbs_ack_i,
  input  logic [31:0] wbs_rdata_i,    // DUT read data
  output int          err_cnt_o,
  output int          check_cnt_o,
  output int          pending_o       // Results and reads still owed by the DUT
);

  node_word_t shadow [`KD_NODES];     // What the DUT should hold
  node_addr_t stream_cnt;             // Mirror of the streaming address
  leaf_idx_t exp_q [2][$];            // Expected leaf per lane, oldest first
  int stamp_q [2][$];                 // Cycle each patch was taken
  logic rd_pending;
  logic ack_exp;                      // Ack due one clock after acceptance
  logic [31:0] rd_exp;
  logic [31:0] off;
  logic hit;
  int cyc = 0;
  int errs = 0;
  int checks = 0;
  int pending = 0;

  assign err_cnt_o   = errs;
  assign check_cnt_o = checks;
  assign pending_o   = pending;

  // Walk the shadow tree, right child when component >= median
  function automatic leaf_idx_t ref_leaf(input patch_t p);
    int n;
    int dim;
    leaf_idx_t idx;
    n = 0;
    idx = '0;
    for (int lvl = 0; lvl < `KD_DEPTH; lvl++) begin
      dim = (shadow[n].split_dim < `KD_DIMS) ? int'(shadow[n].split_dim) : 0;  // Bad dim acts as 0
      idx = idx << 1;
      if (p[dim] >= shadow[n].median) begin
        idx[0] = 1'b1;
        n = 2 * n + 2;
      end else begin
        n = 2 * n + 1;
      end
    end
    return idx;
  endfunction

  task automatic check_lane(input int lane, input logic en, input leaf_idx_t leaf);
    if (en) begin
      if (exp_q[lane].size() == 0) begin
        errs++;
        $display("[FAIL] %0t: lane %s result with no patch in flight", $time, lane ? "B" : "A");
      end else begin
        checks++;
        if (cyc - stamp_q[lane][0] != `KD_DEPTH) begin
          errs++;
          $display("[FAIL] %0t: lane %s result after %0d cycles", $time, lane ? "B" : "A",
                   cyc - stamp_q[lane][0]);
        end
        if (leaf !== exp_q[lane][0]) begin
          errs++;
          $display("[FAIL] %0t: lane %s leaf %0d, expected %0d", $time, lane ? "B" : "A",
                   leaf, exp_q[lane][0]);
        end
        void'(exp_q[lane].pop_front());
        void'(stamp_q[lane].pop_front());
      end
    end else begin
      if (leaf !== '0) begin
        errs++;
        $display("[FAIL] %0t: lane %s leaf %0d while idle", $time, lane ? "B" : "A", leaf);
      end
      if (exp_q[lane].size() != 0 && cyc - stamp_q[lane][0] >= `KD_DEPTH) begin
        errs++;  // Pulse never came
        $display("[FAIL] %0t: lane %s result missing", $time, lane ? "B" : "A");
        void'(exp_q[lane].pop_front());
        void'(stamp_q[lane].pop_front());
      end
    end
  endtask

  // Sampled mid-cycle, away from the DUT edge and the input drive
  always @(negedge clk) begin
    if (rst_n !== 1'b1) begin
      foreach (shadow[n]) shadow[n] = '0;  // Nodes clear on reset
      stream_cnt = '0;
      for (int l = 0; l < 2; l++) begin
        exp_q[l].delete();
        stamp_q[l].delete();
      end
      rd_pending = 1'b0;
      ack_exp = 1'b0;
      pending = 0;
    end else begin
      cyc++;
      check_lane(0, receiver_en_i, leaf_index_i);
      check_lane(1, receiver_two_en_i, leaf_index_two_i);
      // Ack is a single pulse one clock after each accepted cycle
      if (wbs_ack_i !== ack_exp) begin
        errs++;
        $display("[FAIL] %0t: wishbone ack %b, expected %b", $time, wbs_ack_i, ack_exp);
      end
      ack_exp = 1'b0;
      if (wbs_ack_i) begin
        if (rd_pending) begin
          checks++;
          if (wbs_rdata_i !== rd_exp) begin
            errs++;
            $display("[FAIL] %0t: read data %h, expected %h", $time, wbs_rdata_i, rd_exp);
          end
        end
        rd_pending = 1'b0;
      end
      // Patches see the tree before this edge's writes
      if (patch_en_i) begin
        exp_q[0].push_back(ref_leaf(patch_a_i));
        stamp_q[0].push_back(cyc);
      end
      if (patch_two_en_i) begin
        exp_q[1].push_back(ref_leaf(patch_b_i));
        stamp_q[1].push_back(cyc);
      end
      if (wb_mode_i) begin
        stream_cnt = '0;  // Parked while the bus owns the nodes
        if (wbs_cyc_i && wbs_stb_i && !wbs_ack_i) begin
          ack_exp = 1'b1;
          off = wbs_adr_i - `KD_WB_BASE;
          hit = (off[1:0] == 2'b00) && (off < 4 * `KD_NODES);
          if (wbs_we_i) begin
            if (hit) shadow[off[7:2]] = node_word_t'(wbs_dat_i[21:0]);
          end else begin
            rd_pending = 1'b1;
            rd_exp = hit ? {10'b0, shadow[off[7:2]]} : '0;  // Misses read zero
          end
        end
      end else if (fsm_en_i && sender_en_i) begin
        shadow[stream_cnt] = sender_data_i;
        stream_cnt = (stream_cnt == node_addr_t'(`KD_NODES - 1)) ? '0 : stream_cnt + 1'b1;
      end
      pending = exp_q[0].size() + exp_q[1].size() + int'(rd_pending);
    end
  end

endmodule

// ==== tb/tb_kd_search.sv ====
// Testbench for the KD-tree search accelerator, stream and Wishbone loading plus both lanes
`include "kd_tree_defines.svh"

module tb_kd_search import kd_tree_pkg::*; ();

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic wb_mode_i, fsm_en_i, sender_en_i;
  node_word_t sender_data_i;
  logic patch_en_i, patch_two_en_i;
  patch_t patch_a_i, patch_b_i;
  leaf_idx_t leaf_index_o, leaf_index_two_o;
  logic receiver_en_o, receiver_two_en_o;
  logic wbs_cyc_i, wbs_stb_i, wbs_we_i, wbs_ack_o;
  logic [3:0] wbs_sel_i;
  logic [31:0] wbs_adr_i, wbs_dat_i, wbs_dat_o;
  logic [15:0] lfsr = 16'd67;  // Stimulus seed
  int local_errs = 0;
  int err_cnt, check_cnt, pending;

  kd_search_top UUT (.*);

  kd_search_checker u_checker (
    .clk (clk), .rst_n (rst_n), .wb_mode_i (wb_mode_i),
    .fsm_en_i (fsm_en_i), .sender_en_i (sender_en_i), .sender_data_i (sender_data_i),
    .patch_en_i (patch_en_i), .patch_two_en_i (patch_two_en_i),
    .patch_a_i (patch_a_i), .patch_b_i (patch_b_i),
    .receiver_en_i (receiver_en_o), .receiver_two_en_i (receiver_two_en_o),
    .leaf_index_i (leaf_index_o), .leaf_index_two_i (leaf_index_two_o),
    .wbs_cyc_i (wbs_cyc_i), .wbs_stb_i (wbs_stb_i), .wbs_we_i (wbs_we_i),
    .wbs_adr_i (wbs_adr_i), .wbs_dat_i (wbs_dat_i), .wbs_ack_i (wbs_ack_o),
    .wbs_rdata_i (wbs_dat_o), .err_cnt_o (err_cnt), .check_cnt_o (check_cnt),
    .pending_o (pending)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  // Whole-run watchdog
  initial begin
    for (int c = 0; c < 20000; c++) @(posedge clk);
    $display("Simulation timed out before the test sequence finished");
    $display("Something failed");
    $finish;
  end

  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);  // One step per bit
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic patch_t rand_patch();
    patch_t p;
    for (int d = 0; d < `KD_DIMS; d++) p[d] = comp_t'(take_bits(`KD_COMP_W));
    return p;
  endfunction

  function automatic node_word_t rand_word();
    node_word_t w;
    w.median = comp_t'(take_bits(`KD_COMP_W));
    w.split_dim = comp_t'(take_bits(3) % `KD_DIMS);  // Legal dims only
    return w;
  endfunction

  // Inputs change 2 units after the rising edge
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] dat);
    int t;
    wbs_cyc_i = 1'b1;
    wbs_stb_i = 1'b1;
    wbs_we_i = we;
    wbs_adr_i = adr;
    wbs_dat_i = dat;
    t = 0;
    do begin
      tick();
      t++;
    end while (!wbs_ack_o && t < 16);
    if (!wbs_ack_o) begin
      $display("Wishbone access to %h was never acknowledged", adr);
      local_errs++;
    end
    wbs_cyc_i = 1'b0;  // Drop the request on ack
    wbs_stb_i = 1'b0;
    wbs_we_i = 1'b0;
  endtask

  task automatic stream_load(input int count);
    wb_mode_i = 1'b0;
    fsm_en_i = 1'b1;
    sender_en_i = 1'b1;
    for (int i = 0; i < count; i++) begin
      sender_data_i = rand_word();
      tick();
    end
    sender_en_i = 1'b0;
    fsm_en_i = 1'b0;
  endtask

  // Mode 0 lane A only, 1 both lanes every cycle, 2 random on/off
  task automatic run_patches(input int count, input int mode);
    for (int i = 0; i < count; i++) begin
      patch_en_i = (mode == 2) ? (take_bits(1) != 0) : 1'b1;
      patch_two_en_i = (mode == 2) ? (take_bits(1) != 0) : (mode == 1);
      patch_a_i = rand_patch();
      patch_b_i = rand_patch();
      tick();
    end
    patch_en_i = 1'b0;
    patch_two_en_i = 1'b0;
    for (int t = 0; t < 40 && pending != 0; t++) tick();
    if (pending != 0) begin
      $display("Search results were still outstanding after the pipeline drained");
      local_errs++;
    end
  endtask

  initial begin
    wb_mode_i = 1'b0;
    fsm_en_i = 1'b0;
    sender_en_i = 1'b0;
    sender_data_i = '0;
    patch_en_i = 1'b0;
    patch_two_en_i = 1'b0;
    patch_a_i = '0;
    patch_b_i = '0;
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_we_i = 1'b0;
    wbs_sel_i = 4'hF;  // Whole-word writes
    wbs_adr_i = '0;
    wbs_dat_i = '0;
    repeat (16) tick();
    rst_n = 1'b1;
    for (int i = 0; i < 8; i++) begin
      if (receiver_en_o !== 1'b0 || receiver_two_en_o !== 1'b0 || wbs_ack_o !== 1'b0) begin
        $display("[FAIL] %0t: output active after reset", $time);
        local_errs++;
      end
      tick();
    end
    wb_mode_i = 1'b1;
    for (int n = 0; n < `KD_NODES; n += 9) wb_access(1'b0, `KD_WB_BASE + 4 * n, '0);
    stream_load(`KD_NODES);
    run_patches(200, 0);
    // Bus rewrites, root first
    wb_mode_i = 1'b1;
    wb_access(1'b1, `KD_WB_BASE, {10'b0, rand_word()});
    for (int i = 0; i < 6; i++) begin
      wb_access(1'b1, `KD_WB_BASE + 4 * (take_bits(6) % `KD_NODES), {10'b0, rand_word()});
    end
    run_patches(100, 0);
    for (int n = 0; n < `KD_NODES; n++) wb_access(1'b0, `KD_WB_BASE + 4 * n, '0);
    wb_access(1'b0, `KD_WB_BASE + 4 * `KD_NODES, '0);  // Past the last node
    wb_access(1'b0, `KD_WB_BASE + 2, '0);              // Unaligned
    wb_access(1'b0, `KD_WB_BASE - 4, '0);              // Below the base
    run_patches(100, 1);
    run_patches(300, 2);
    // Illegal split dims at the root and its left child
    wb_access(1'b1, `KD_WB_BASE, {10'b0, 11'd700, 11'd6});
    wb_access(1'b1, `KD_WB_BASE + 4, {10'b0, comp_t'(take_bits(11)), 11'h7FF});
    run_patches(100, 1);
    stream_load(`KD_NODES + 3);  // Last three land on nodes 0 to 2
    wb_mode_i = 1'b1;
    for (int n = 0; n < 3; n++) wb_access(1'b0, `KD_WB_BASE + 4 * n, '0);
    run_patches(100, 1);
    tick();
    $display("Checks %0d, checker errors %0d, testbench errors %0d",
             check_cnt, err_cnt, local_errs);
    if (err_cnt == 0 && local_errs == 0 && check_cnt > 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/kd_tree_pkg.sv
rtl/internal_node.sv
rtl/node_loader.sv
rtl/internal_node_tree.sv
rtl/kd_search_top.sv
tb/kd_search_checker.sv
tb/tb_kd_search.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_kd_search
RTL_TOP  = kd_search_top
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Something failed" $(LOG) || ! grep -q "Everything OK" $(LOG); then \
	  echo "Simulation reported a failure"; exit 1; fi

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
